// ==== Bender.yml ====
package:
  name: cached_afu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/afu_pkg.sv
      - source/reset_control.sv
      - source/mmio.sv
      - source/job.sv
      - source/cached_afu.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/cached_afu_tb.sv

// ==== source/afu_config.svh ====
`ifndef AFU_CONFIG_SVH
`define AFU_CONFIG_SVH

// mmio data bus and wed pointer width
`define AFU_DATA_WIDTH 64

// mmio word address width
`define AFU_MMIO_ADDR_WIDTH 24

// job error bits for command parity, mmio address parity and mmio data parity
`define AFU_ERROR_WIDTH 3

// cycles afu_rst_n stays low after the last request
`define AFU_RESET_CYCLES 4

// doubleword register map, bit 0 always clear
`define AFU_REG_CONTROL 24'h000000
`define AFU_REG_STATUS  24'h000002
`define AFU_REG_WED     24'h000004
`define AFU_REG_SCRATCH 24'h000006

`endif

// ==== source/afu_pkg.sv ====
`include "afu_config.svh"

package afu_pkg;

  // job commands from the host service layer
  typedef enum logic [1:0] {
    job_start    = 2'd0,
    job_reset    = 2'd1,
    job_timebase = 2'd2,
    job_none     = 2'd3
  } job_cmd_t;

  // one mmio data beat read as a doubleword or as two 32-bit words
  typedef union packed {
    logic [`AFU_DATA_WIDTH-1:0] dw;
    struct packed {
      logic [`AFU_DATA_WIDTH/2-1:0] hi;
      logic [`AFU_DATA_WIDTH/2-1:0] lo;
    } words;
  } mmio_data_t;

endpackage

// ==== source/cached_afu.sv ====
`timescale 1ns/1ns

`include "afu_config.svh"

module cached_afu
  import afu_pkg::*;
(
  input  logic                            clock,
  input  logic                            rst_n,
  // job control
  input  logic                            job_valid,
  input  job_cmd_t                        job_command,
  input  logic                            job_command_parity,
  input  logic [`AFU_DATA_WIDTH-1:0]      job_address,
  output logic                            job_running,
  output logic                            job_done,
  output logic [`AFU_ERROR_WIDTH-1:0]     job_error,
  // mmio
  input  logic                            mmio_valid,
  input  logic                            mmio_read,
  input  logic                            mmio_dw,
  input  logic [`AFU_MMIO_ADDR_WIDTH-1:0] mmio_address,
  input  logic                            mmio_address_parity,
  input  mmio_data_t                      mmio_data,
  input  logic                            mmio_data_parity,
  output logic                            mmio_ack,
  output mmio_data_t                      mmio_rdata,
  output logic                            mmio_rdata_parity,
  output logic                            timebase_request,
  output logic                            parity_enabled
);

  localparam int NUM_RESET_REQUESTS = 2;

  // index 0 from job, index 1 from mmio
  logic [NUM_RESET_REQUESTS-1:0] external_rst_n;
  logic                          afu_rst_n;
  logic                          reset_done;
  logic [1:0]                    mmio_errors;
  logic [`AFU_DATA_WIDTH-1:0]    wed_address;

  reset_control #(
    .NUM_EXTERNAL_RESETS(NUM_RESET_REQUESTS)
  ) reset_instant (
    .clock          (clock),
    .rst_n          (rst_n),
    .external_rst_n (external_rst_n),
    .afu_rst_n      (afu_rst_n),
    .reset_done     (reset_done)
  );

  mmio mmio_instant (
    .clock               (clock),
    .afu_rst_n           (afu_rst_n),
    .mmio_valid          (mmio_valid),
    .mmio_read           (mmio_read),
    .mmio_dw             (mmio_dw),
    .mmio_address        (mmio_address),
    .mmio_address_parity (mmio_address_parity),
    .mmio_data           (mmio_data),
    .mmio_data_parity    (mmio_data_parity),
    .job_running         (job_running),
    .wed_address         (wed_address),
    .mmio_ack            (mmio_ack),
    .mmio_rdata          (mmio_rdata),
    .mmio_rdata_parity   (mmio_rdata_parity),
    .mmio_errors         (mmio_errors),
    .parity_enabled      (parity_enabled),
    .reset_mmio          (external_rst_n[1])
  );

  job job_instant (
    .clock              (clock),
    .afu_rst_n          (afu_rst_n),
    .job_valid          (job_valid),
    .job_command        (job_command),
    .job_command_parity (job_command_parity),
    .job_address        (job_address),
    .mmio_errors        (mmio_errors),
    .parity_enabled     (parity_enabled),
    .reset_done         (reset_done),
    .job_running        (job_running),
    .job_done           (job_done),
    .job_error          (job_error),
    .timebase_request   (timebase_request),
    .reset_job          (external_rst_n[0]),
    .wed_address        (wed_address)
  );

endmodule

// ==== source/job.sv ====
`timescale 1ns/1ns

`include "afu_config.svh"

module job
  import afu_pkg::*;
(
  input  logic                        clock,
  input  logic                        afu_rst_n,
  input  logic                        job_valid,
  input  job_cmd_t                    job_command,
  input  logic                        job_command_parity,
  input  logic [`AFU_DATA_WIDTH-1:0]  job_address,
  input  logic [1:0]                  mmio_errors,
  input  logic                        parity_enabled,
  input  logic                        reset_done,
  output logic                        job_running,
  output logic                        job_done,
  output logic [`AFU_ERROR_WIDTH-1:0] job_error,
  output logic                        timebase_request,
  output logic                        reset_job,
  output logic [`AFU_DATA_WIDTH-1:0]  wed_address
);

  localparam logic STATE_IDLE    = 1'b0;
  localparam logic STATE_RUNNING = 1'b1;

  logic                        state;
  logic                        command_parity_error;
  logic                        command_accepted;
  logic                        start_accepted;
  logic [`AFU_ERROR_WIDTH-1:0] new_errors;

  // odd parity over the command field
  assign command_parity_error = job_valid && parity_enabled &&
                                !(^{job_command, job_command_parity});
  assign command_accepted = job_valid && !command_parity_error;
  assign start_accepted   = command_accepted && (job_command == job_start) &&
                            (state == STATE_IDLE);

  // bit 0 command, bit 1 mmio address, bit 2 mmio data
  assign new_errors = {mmio_errors[1], mmio_errors[0], command_parity_error};

  assign job_running = (state == STATE_RUNNING);

  always_ff @(posedge clock) begin
    if (!afu_rst_n) begin
      state            <= STATE_IDLE;
      job_done         <= 1'b0;
      job_error        <= '0;
      timebase_request <= 1'b0;
      reset_job        <= 1'b1;
    end else begin
      job_done         <= 1'b0;
      timebase_request <= 1'b0;
      reset_job        <= 1'b1;
      job_error        <= job_error | new_errors;

      // completion of a requested reset
      if (reset_done) begin
        job_done <= 1'b1;
      end

      case (state)
        STATE_IDLE: begin
          if (command_parity_error) begin
            job_done <= 1'b1;
          end else if (start_accepted) begin
            state <= STATE_RUNNING;
          end
        end
        STATE_RUNNING: begin
          // any error aborts the running job
          if (|new_errors) begin
            state    <= STATE_IDLE;
            job_done <= 1'b1;
          end
        end
        default: state <= STATE_IDLE;
      endcase

      if (command_accepted) begin
        case (job_command)
          job_reset:    reset_job <= 1'b0;
          job_timebase: timebase_request <= 1'b1;
          // start handled by the state machine above
          job_start:    ;
          job_none:     ;
          default:      ;
        endcase
      end
    end
  end

  // wed pointer captured when a job starts
  always_ff @(posedge clock) begin
    if (start_accepted) begin
      wed_address <= job_address;
    end
  end

endmodule

// ==== source/mmio.sv ====
`timescale 1ns/1ns

`include "afu_config.svh"

module mmio
  import afu_pkg::*;
(
  input  logic                            clock,
  input  logic                            afu_rst_n,
  input  logic                            mmio_valid,
  input  logic                            mmio_read,
  input  logic                            mmio_dw,
  input  logic [`AFU_MMIO_ADDR_WIDTH-1:0] mmio_address,
  input  logic                            mmio_address_parity,
  input  mmio_data_t                      mmio_data,
  input  logic                            mmio_data_parity,
  input  logic                            job_running,
  input  logic [`AFU_DATA_WIDTH-1:0]      wed_address,
  output logic                            mmio_ack,
  output mmio_data_t                      mmio_rdata,
  output logic                            mmio_rdata_parity,
  output logic [1:0]                      mmio_errors,
  output logic                            parity_enabled,
  output logic                            reset_mmio
);

  logic [`AFU_MMIO_ADDR_WIDTH-1:0] dw_address;
  logic                            word_hi;
  logic                            address_parity_error;
  logic                            data_parity_error;
  logic                            write_enable;
  logic [`AFU_DATA_WIDTH/2-1:0]    read_word;

  mmio_data_t scratch;
  mmio_data_t control_value;
  mmio_data_t status_value;
  mmio_data_t wed_value;
  mmio_data_t register_value;
  mmio_data_t read_value;
  mmio_data_t control_next;
  mmio_data_t scratch_next;

  // word writes carry the data duplicated, so the matching half is taken
  function automatic mmio_data_t merge_write(mmio_data_t old_value, mmio_data_t wdata,
                                             logic dw, logic hi);
    mmio_data_t result;
    result = old_value;
    if (dw) begin
      result = wdata;
    end else if (hi) begin
      result.words.hi = wdata.words.hi;
    end else begin
      result.words.lo = wdata.words.lo;
    end
    return result;
  endfunction

  assign dw_address = {mmio_address[`AFU_MMIO_ADDR_WIDTH-1:1], 1'b0};
  assign word_hi    = mmio_address[0];

  // odd parity means a good field has an odd count of ones
  assign address_parity_error = mmio_valid && parity_enabled &&
                                !(^{mmio_address, mmio_address_parity});
  assign data_parity_error    = mmio_valid && !mmio_read && parity_enabled &&
                                !(^{mmio_data.dw, mmio_data_parity});
  assign write_enable = mmio_valid && !mmio_read && !address_parity_error &&
                        !data_parity_error;

  // soft reset bit always reads back as 0
  assign control_value.dw = {{(`AFU_DATA_WIDTH-1){1'b0}}, parity_enabled};
  assign status_value.dw  = {{(`AFU_DATA_WIDTH-1){1'b0}}, job_running};
  assign wed_value.dw     = wed_address;

  assign control_next = merge_write(control_value, mmio_data, mmio_dw, word_hi);
  assign scratch_next = merge_write(scratch, mmio_data, mmio_dw, word_hi);

  always_comb begin
    case (dw_address)
      `AFU_REG_CONTROL: register_value = control_value;
      `AFU_REG_STATUS:  register_value = status_value;
      `AFU_REG_WED:     register_value = wed_value;
      `AFU_REG_SCRATCH: register_value = scratch;
      default:          register_value = '1;
    endcase
    read_word  = word_hi ? register_value.words.hi : register_value.words.lo;
    read_value = register_value;
    if (!mmio_dw) begin
      read_value.words.hi = read_word;
      read_value.words.lo = read_word;
    end
  end

  always_ff @(posedge clock) begin
    if (!afu_rst_n) begin
      mmio_ack       <= 1'b0;
      mmio_errors    <= 2'b00;
      parity_enabled <= 1'b0;
      reset_mmio     <= 1'b1;
      scratch        <= '0;
    end else begin
      mmio_ack    <= mmio_valid;
      mmio_errors <= {data_parity_error, address_parity_error};
      reset_mmio  <= 1'b1;
      if (write_enable) begin
        case (dw_address)
          `AFU_REG_CONTROL: begin
            parity_enabled <= control_next.dw[0];
            reset_mmio     <= !control_next.dw[1];
          end
          `AFU_REG_SCRATCH: scratch <= scratch_next;
          // status, wed and unmapped addresses drop writes
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mmio_valid && mmio_read) begin
      mmio_rdata <= read_value;
    end
  end

  assign mmio_rdata_parity = ~^mmio_rdata.dw;

endmodule

// ==== source/reset_control.sv ====
`timescale 1ns/1ns

`include "afu_config.svh"

module reset_control #(
  parameter int NUM_EXTERNAL_RESETS = 2
) (
  input  logic                           clock,
  input  logic                           rst_n,
  input  logic [NUM_EXTERNAL_RESETS-1:0] external_rst_n,
  output logic                           afu_rst_n,
  output logic                           reset_done
);

  localparam int COUNT_WIDTH = $clog2(`AFU_RESET_CYCLES + 1);
  localparam logic [COUNT_WIDTH-1:0] RESET_LOAD = COUNT_WIDTH'(`AFU_RESET_CYCLES);
  localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(1);

  logic [COUNT_WIDTH-1:0] count;
  logic                   from_external;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      count         <= RESET_LOAD;
      from_external <= 1'b0;
      reset_done    <= 1'b0;
    end else if (!(&external_rst_n)) begin
      // a held request keeps reloading the stretch
      count         <= RESET_LOAD;
      from_external <= 1'b1;
      reset_done    <= 1'b0;
    end else begin
      // only internally requested resets report completion
      reset_done <= from_external && (count == LAST_COUNT);
      if (count == LAST_COUNT) begin
        from_external <= 1'b0;
      end
      if (count != '0) begin
        count <= count - 1'b1;
      end
    end
  end

  assign afu_rst_n = (count == '0);

endmodule

// ==== sources.f ====
+incdir+source
source/afu_pkg.sv
source/reset_control.sv
source/mmio.sv
source/job.sv
source/cached_afu.sv
verification/cached_afu_tb.sv

// ==== verification/cached_afu_tb.sv ====
`timescale 1ns/1ns

`include "afu_config.svh"

module cached_afu_tb
  import afu_pkg::*;
();

  localparam int ACK_TIMEOUT  = 20;
  localparam int DONE_TIMEOUT = 40;
  localparam logic [`AFU_MMIO_ADDR_WIDTH-1:0] UNMAPPED_ADDR = 24'h000010;

  logic                            clock;
  logic                            rst_n;
  logic                            job_valid;
  job_cmd_t                        job_command;
  logic                            job_command_parity;
  logic [`AFU_DATA_WIDTH-1:0]      job_address;
  logic                            job_running;
  logic                            job_done;
  logic [`AFU_ERROR_WIDTH-1:0]     job_error;
  logic                            mmio_valid;
  logic                            mmio_read;
  logic                            mmio_dw;
  logic [`AFU_MMIO_ADDR_WIDTH-1:0] mmio_address;
  logic                            mmio_address_parity;
  mmio_data_t                      mmio_data;
  logic                            mmio_data_parity;
  logic                            mmio_ack;
  mmio_data_t                      mmio_rdata;
  logic                            mmio_rdata_parity;
  logic                            timebase_request;
  logic                            parity_enabled;

  integer seed;
  int     mismatch_count;
  int     timeout_count;

  cached_afu UUT (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic check_data(input string name, input mmio_data_t expected,
                            input mmio_data_t actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, actual %h", name, expected.dw, actual.dw);
      mismatch_count++;
    end
  endtask

  task automatic check_error(input string name, input logic [`AFU_ERROR_WIDTH-1:0] expected,
                             input logic [`AFU_ERROR_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %b, actual %b", name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("FAILED %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
      mismatch_count++;
    end
  endtask

  function automatic mmio_data_t random_data();
    mmio_data_t value;
    value.words.hi = $random(seed);
    value.words.lo = $random(seed);
    return value;
  endfunction

  task automatic drive_idle();
    job_valid           = 1'b0;
    job_command         = job_none;
    job_command_parity  = 1'b0;
    job_address         = '0;
    mmio_valid          = 1'b0;
    mmio_read           = 1'b0;
    mmio_dw             = 1'b0;
    mmio_address        = '0;
    mmio_address_parity = 1'b0;
    mmio_data           = '0;
    mmio_data_parity    = 1'b0;
  endtask

  task automatic apply_reset();
    @(negedge clock);
    drive_idle();
    rst_n = 1'b0;
    repeat (4) @(negedge clock);
    rst_n = 1'b1;
    // afu_rst_n is still stretched after rst_n rises
    repeat (`AFU_RESET_CYCLES + 2) @(negedge clock);
  endtask

  // the negedge after the strobe counts as cycle 1
  task automatic wait_ack(input string name);
    int cycles;
    cycles = 1;
    while (mmio_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (mmio_ack !== 1'b1) begin
      $display("%s: no mmio_ack within %0d cycles", name, ACK_TIMEOUT);
      timeout_count++;
    end else begin
      check_latency({name, " ack"}, 1, cycles);
    end
  endtask

  // the negedge after the strobe counts as cycle 1
  task automatic wait_done(input string name, output int cycles);
    cycles = 1;
    while (job_done !== 1'b1 && cycles < DONE_TIMEOUT) begin
      @(negedge clock);
      cycles++;
    end
    if (job_done !== 1'b1) begin
      $display("%s: no job_done within %0d cycles", name, DONE_TIMEOUT);
      timeout_count++;
    end
  endtask

  task automatic mmio_write(input string name, input logic [`AFU_MMIO_ADDR_WIDTH-1:0] address,
                            input logic dw, input mmio_data_t data,
                            input logic bad_address_parity, input logic bad_data_parity);
    @(negedge clock);
    mmio_valid          = 1'b1;
    mmio_read           = 1'b0;
    mmio_dw             = dw;
    mmio_address        = address;
    mmio_address_parity = (~^address) ^ bad_address_parity;
    mmio_data           = data;
    mmio_data_parity    = (~^data.dw) ^ bad_data_parity;
    @(negedge clock);
    mmio_valid = 1'b0;
    wait_ack(name);
  endtask

  task automatic mmio_read_access(input string name,
                                  input logic [`AFU_MMIO_ADDR_WIDTH-1:0] address,
                                  input logic dw, output mmio_data_t data, output logic parity);
    @(negedge clock);
    mmio_valid          = 1'b1;
    mmio_read           = 1'b1;
    mmio_dw             = dw;
    mmio_address        = address;
    mmio_address_parity = ~^address;
    mmio_data           = '0;
    mmio_data_parity    = 1'b1;
    @(negedge clock);
    mmio_valid = 1'b0;
    mmio_read  = 1'b0;
    wait_ack(name);
    data   = mmio_rdata;
    parity = mmio_rdata_parity;
  endtask

  task automatic job_send(input job_cmd_t command, input logic [`AFU_DATA_WIDTH-1:0] address,
                          input logic bad_parity);
    @(negedge clock);
    job_valid          = 1'b1;
    job_command        = command;
    job_command_parity = (~^command) ^ bad_parity;
    job_address        = address;
    @(negedge clock);
    job_valid   = 1'b0;
    job_command = job_none;
  endtask

  task automatic enable_parity();
    mmio_data_t value;
    value.dw = 64'h1;
    mmio_write("control parity enable", `AFU_REG_CONTROL, 1'b1, value, 1'b0, 1'b0);
    check_bit("parity enable", 1'b1, parity_enabled);
  endtask

  task automatic read_and_check(input string name, input logic [`AFU_MMIO_ADDR_WIDTH-1:0] address,
                                input logic dw, input mmio_data_t expected);
    mmio_data_t read_data;
    logic       read_parity;
    mmio_read_access(name, address, dw, read_data, read_parity);
    check_data(name, expected, read_data);
    // odd parity over the returned doubleword
    check_bit({name, " parity"}, ~^expected.dw, read_parity);
  endtask

  task automatic scratch_access();
    mmio_data_t written;
    mmio_data_t word_data;
    mmio_data_t expected;
    logic [31:0] hi_word;
    apply_reset();
    written = random_data();
    mmio_write("scratch dw write", `AFU_REG_SCRATCH, 1'b1, written, 1'b0, 1'b0);
    read_and_check("scratch dw read", `AFU_REG_SCRATCH, 1'b1, written);
    hi_word            = $random(seed);
    word_data.words.hi = hi_word;
    word_data.words.lo = hi_word;
    mmio_write("scratch hi write", `AFU_REG_SCRATCH | 24'h1, 1'b0, word_data, 1'b0, 1'b0);
    expected          = written;
    expected.words.hi = hi_word;
    read_and_check("scratch after hi write", `AFU_REG_SCRATCH, 1'b1, expected);
    // word reads return the chosen word twice
    read_and_check("scratch hi word read", `AFU_REG_SCRATCH | 24'h1, 1'b0, word_data);
    expected.words.hi = written.words.lo;
    expected.words.lo = written.words.lo;
    read_and_check("scratch lo word read", `AFU_REG_SCRATCH, 1'b0, expected);
  endtask

  task automatic unmapped_and_parity_guard();
    mmio_data_t all_ones;
    mmio_data_t original;
    apply_reset();
    all_ones.dw = '1;
    read_and_check("unmapped read", UNMAPPED_ADDR, 1'b1, all_ones);
    enable_parity();
    original = random_data();
    mmio_write("scratch good write", `AFU_REG_SCRATCH, 1'b1, original, 1'b0, 1'b0);
    mmio_write("bad address parity", `AFU_REG_SCRATCH, 1'b1, random_data(), 1'b1, 1'b0);
    read_and_check("scratch after bad address", `AFU_REG_SCRATCH, 1'b1, original);
    mmio_write("bad data parity", `AFU_REG_SCRATCH, 1'b1, random_data(), 1'b0, 1'b1);
    read_and_check("scratch after bad data", `AFU_REG_SCRATCH, 1'b1, original);
  endtask

  task automatic start_job();
    mmio_data_t wed;
    mmio_data_t status;
    apply_reset();
    wed = random_data();
    job_send(job_start, wed.dw, 1'b0);
    check_bit("running after start", 1'b1, job_running);
    status.dw = 64'h1;
    read_and_check("status while running", `AFU_REG_STATUS, 1'b1, status);
    read_and_check("wed readback", `AFU_REG_WED, 1'b1, wed);
  endtask

  task automatic error_abort();
    int cycles;
    apply_reset();
    enable_parity();
    job_send(job_start, random_data(), 1'b0);
    mmio_write("bad address while running", `AFU_REG_SCRATCH, 1'b1, random_data(), 1'b1, 1'b0);
    wait_done("mmio error abort", cycles);
    // job_done lands one cycle after the mmio error strobe
    check_latency("mmio error abort", 2, cycles);
    check_error("mmio error abort", 3'b010, job_error);
    check_bit("running after abort", 1'b0, job_running);
    // command parity error in idle
    apply_reset();
    enable_parity();
    job_send(job_start, '0, 1'b1);
    wait_done("command parity error", cycles);
    check_latency("command parity error", 1, cycles);
    check_error("command parity error", 3'b001, job_error);
    check_bit("running after bad start", 1'b0, job_running);
  endtask

  task automatic reset_command();
    mmio_data_t zero;
    int cycles;
    apply_reset();
    enable_parity();
    mmio_write("scratch before reset", `AFU_REG_SCRATCH, 1'b1, random_data(), 1'b0, 1'b0);
    // leave a sticky error behind for the reset to clear
    mmio_write("bad address before reset", `AFU_REG_SCRATCH, 1'b1, random_data(), 1'b1, 1'b0);
    job_send(job_start, random_data(), 1'b0);
    check_error("error before reset command", 3'b010, job_error);
    job_send(job_reset, '0, 1'b0);
    wait_done("reset command", cycles);
    check_latency("reset command", `AFU_RESET_CYCLES + 3, cycles);
    zero.dw = '0;
    read_and_check("scratch after reset command", `AFU_REG_SCRATCH, 1'b1, zero);
    check_bit("parity after reset command", 1'b0, parity_enabled);
    check_error("error after reset command", '0, job_error);
    check_bit("running after reset command", 1'b0, job_running);
  endtask

  task automatic timebase_and_soft_reset();
    mmio_data_t control;
    mmio_data_t zero;
    int cycles;
    apply_reset();
    job_send(job_timebase, '0, 1'b0);
    check_bit("timebase pulse", 1'b1, timebase_request);
    @(negedge clock);
    check_bit("timebase pulse end", 1'b0, timebase_request);
    enable_parity();
    mmio_write("scratch before soft reset", `AFU_REG_SCRATCH, 1'b1, random_data(), 1'b0, 1'b0);
    control.dw = 64'h3;
    mmio_write("soft reset write", `AFU_REG_CONTROL, 1'b1, control, 1'b0, 1'b0);
    // reset completion also shows up as job_done
    wait_done("soft reset", cycles);
    zero.dw = '0;
    read_and_check("scratch after soft reset", `AFU_REG_SCRATCH, 1'b1, zero);
    check_bit("parity after soft reset", 1'b0, parity_enabled);
  endtask

  initial begin
    seed           = 82;
    mismatch_count = 0;
    timeout_count  = 0;
    rst_n          = 1'b0;
    drive_idle();
    scratch_access();
    unmapped_and_parity_guard();
    start_job();
    error_abort();
    reset_command();
    timebase_and_soft_reset();
    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
